// ==== obj_consts.svh ====
// Sizes, address widths and register map of the sprite engine
`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

// Object table
`define OBJ_COUNT 24
`define OBJ_IDX_W 5

// Line buffer and graphics ROM
`define LINE_W 8
`define ROM_AW 13

// Colour table is addressed by palette bank and pixel
`define PAL_AW 8

// AXI4-Lite register map, byte addresses
`define AXI_AW 12
`define REG_CTRL 'h000
`define REG_OBJ_BASE 'h400
`define REG_PAL_BASE 'h800

`define HOFFSET_RST 8'd6

`endif

// ==== obj_pkg.sv ====
// Object table entry, draw request and scan state types
`default_nettype none

package obj_pkg;

    // One table entry as the CPU writes it
    // attr: palette bank in 3..0, hflip in 6, vflip in 7
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] attr;
        logic [7:0] code;
        logic [7:0] x;
    } obj_entry_t;

    // Work handed from the scan to the draw unit
    typedef struct packed {
        logic [7:0] attr;
        logic [7:0] code;
        logic [7:0] x;
        logic [3:0] row;
    } draw_req_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_TEST,
        SCAN_WAIT
    } scan_state_e;

endpackage

`default_nettype wire

// ==== axil_pkg.sv ====
// AXI4-Lite response codes and register region decode type
`default_nettype none

package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    typedef enum logic [1:0] {
        REGION_CTRL,
        REGION_OBJ,
        REGION_PAL,
        REGION_NONE
    } reg_region_e;

endpackage

`default_nettype wire

// ==== obj_axil_regs.sv ====
// AXI4-Lite slave with object RAM, colour table, control register and engine read ports
`timescale 1ns/1ps
`default_nettype none
`include "obj_consts.svh"

module obj_axil_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`AXI_AW-1:0]       awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`AXI_AW-1:0]       araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     enable,
    output logic [7:0]               hoffset,
    input  logic [`OBJ_IDX_W-1:0]    obj_rd_addr,
    output obj_pkg::obj_entry_t      obj_rd_data,
    input  logic [`PAL_AW-1:0]       pal_rd_addr,
    output logic [3:0]               pal_rd_data
);

    obj_pkg::obj_entry_t     obj_ram [`OBJ_COUNT];
    logic [3:0]              pal_ram [2**`PAL_AW];
    axil_pkg::reg_region_e   wr_region;
    axil_pkg::reg_region_e   rd_region;
    logic                    wr_take;
    logic                    rd_take;
    logic [`OBJ_IDX_W-1:0]   wr_obj_idx;
    logic [`OBJ_IDX_W-1:0]   rd_obj_idx;
    logic [`PAL_AW-1:0]      wr_pal_idx;
    logic [`PAL_AW-1:0]      rd_pal_idx;

    function automatic axil_pkg::reg_region_e region_of(input logic [`AXI_AW-1:0] addr);
        if (addr[`AXI_AW-1:2] == (`REG_CTRL >> 2))
            return axil_pkg::REGION_CTRL;
        if (addr >= `REG_OBJ_BASE && addr < `REG_OBJ_BASE + 4 * `OBJ_COUNT)
            return axil_pkg::REGION_OBJ;
        if (addr >= `REG_PAL_BASE && addr < `REG_PAL_BASE + 4 * 2**`PAL_AW)
            return axil_pkg::REGION_PAL;
        return axil_pkg::REGION_NONE;
    endfunction

    assign wr_region  = region_of(awaddr);
    assign rd_region  = region_of(araddr);
    // Region bases are aligned, so the low address bits index directly
    assign wr_obj_idx = awaddr[`OBJ_IDX_W+1:2];
    assign rd_obj_idx = araddr[`OBJ_IDX_W+1:2];
    assign wr_pal_idx = awaddr[`PAL_AW+1:2];
    assign rd_pal_idx = araddr[`PAL_AW+1:2];

    // Address and data are taken together, one write in flight
    assign wr_take = awvalid && wvalid && !bvalid;
    assign awready = wr_take;
    assign wready  = wr_take;
    assign rd_take = arvalid && !rvalid;
    assign arready = !rvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid  <= 1'b0;
            bresp   <= axil_pkg::RESP_OKAY;
            rvalid  <= 1'b0;
            rresp   <= axil_pkg::RESP_OKAY;
            enable  <= 1'b0;
            hoffset <= `HOFFSET_RST;
        end else begin
            if (wr_take) begin
                bvalid <= 1'b1;
                bresp  <= (wr_region == axil_pkg::REGION_NONE) ?
                          axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
                if (wr_region == axil_pkg::REGION_CTRL) begin
                    if (wstrb[0])
                        enable <= wdata[0];
                    if (wstrb[1])
                        hoffset <= wdata[15:8];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_take) begin
                rvalid <= 1'b1;
                rresp  <= (rd_region == axil_pkg::REGION_NONE) ?
                          axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Memories, CPU read data and the engine-side read ports
    always_ff @(posedge clk) begin
        if (wr_take && wr_region == axil_pkg::REGION_OBJ) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b])
                    obj_ram[wr_obj_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        if (wr_take && wr_region == axil_pkg::REGION_PAL && wstrb[0])
            pal_ram[wr_pal_idx] <= wdata[3:0];

        if (rd_take) begin
            case (rd_region)
                axil_pkg::REGION_CTRL: rdata <= {16'd0, hoffset, 7'd0, enable};
                axil_pkg::REGION_OBJ:  rdata <= obj_ram[rd_obj_idx];
                axil_pkg::REGION_PAL:  rdata <= {28'd0, pal_ram[rd_pal_idx]};
                default:               rdata <= 32'd0;
            endcase
        end

        obj_rd_data <= obj_ram[obj_rd_addr];
        pal_rd_data <= pal_ram[pal_rd_addr];
    end

endmodule

`default_nettype wire

// ==== obj_scan.sv ====
// Per-line object table scan with zone test and draw request hand-off
`timescale 1ns/1ps
`default_nettype none
`include "obj_consts.svh"

module obj_scan (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  logic                     hinit,
    input  logic [7:0]               vrender,
    output logic [`OBJ_IDX_W-1:0]    obj_rd_addr,
    input  obj_pkg::obj_entry_t      obj_rd_data,
    output obj_pkg::draw_req_t       draw_req,
    output logic                     draw_valid,
    input  logic                     draw_busy
);

    obj_pkg::scan_state_e    state;
    logic [`OBJ_IDX_W-1:0]   idx;
    logic [8:0]              y_end;
    logic [7:0]              row_diff;
    logic                    inzone;
    logic                    last;
    logic                    issue;

    assign obj_rd_addr = idx;

    // 9-bit end of band so objects near the bottom do not wrap
    assign y_end    = {1'b0, obj_rd_data.y} + 9'd16;
    assign inzone   = (obj_rd_data.y <= vrender) && ({1'b0, vrender} < y_end);
    assign row_diff = vrender - obj_rd_data.y;
    assign last     = (idx == `OBJ_IDX_W'(`OBJ_COUNT - 1));
    assign issue    = (state == obj_pkg::SCAN_TEST) && inzone && !draw_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= obj_pkg::SCAN_IDLE;
            idx        <= '0;
            draw_valid <= 1'b0;
        end else begin
            case (state)
                obj_pkg::SCAN_IDLE: begin
                    if (hinit && enable) begin
                        idx   <= '0;
                        state <= obj_pkg::SCAN_READ;
                    end
                end
                // RAM address is out, entry arrives next cycle
                obj_pkg::SCAN_READ: state <= obj_pkg::SCAN_TEST;
                obj_pkg::SCAN_TEST: begin
                    if (!inzone) begin
                        state <= obj_pkg::SCAN_WAIT;
                    end else if (issue) begin
                        draw_valid <= 1'b1;
                        state      <= obj_pkg::SCAN_WAIT;
                    end
                end
                obj_pkg::SCAN_WAIT: begin
                    // Hold the request until the draw unit shows busy
                    if (!draw_valid || draw_busy) begin
                        draw_valid <= 1'b0;
                        idx        <= idx + 1'b1;
                        state      <= last ? obj_pkg::SCAN_IDLE : obj_pkg::SCAN_READ;
                    end
                end
                default: state <= obj_pkg::SCAN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            draw_req.attr <= obj_rd_data.attr;
            draw_req.code <= obj_rd_data.code;
            draw_req.x    <= obj_rd_data.x;
            draw_req.row  <= row_diff[3:0];
        end
    end

endmodule

`default_nettype wire

// ==== obj_draw.sv ====
// Object draw unit with ROM fetch, pixel shift, flips and colour lookup
`timescale 1ns/1ps
`default_nettype none
`include "obj_consts.svh"

module obj_draw (
    input  logic                  clk,
    input  logic                  rst,
    input  obj_pkg::draw_req_t    draw_req,
    input  logic                  draw_valid,
    output logic                  draw_busy,
    input  logic [7:0]            hoffset,
    output logic [`ROM_AW-1:0]    rom_addr,
    output logic                  rom_cs,
    input  logic [31:0]           rom_data,
    input  logic                  rom_ok,
    output logic [`PAL_AW-1:0]    pal_rd_addr,
    input  logic [3:0]            pal_rd_data,
    output logic                  buf_we,
    output logic [`LINE_W-1:0]    buf_addr,
    output logic [3:0]            buf_data
);

    obj_pkg::draw_req_t    req;
    logic [31:0]           pxl_word;
    logic [`LINE_W-1:0]    pos;
    logic [`LINE_W-1:0]    start_pos;
    logic [2:0]            cnt;
    logic                  shifting;
    logic                  take;
    logic                  word_in;
    logic                  req_hflip;
    logic                  req_vflip;
    logic                  hflip;

    assign take      = draw_valid && !draw_busy;
    assign word_in   = rom_cs && rom_ok;
    assign req_hflip = draw_req.attr[6];
    assign req_vflip = draw_req.attr[7];
    assign hflip     = req.attr[6];

    // Mirrored objects start at their right edge
    assign start_pos = draw_req.x + hoffset + (req_hflip ? 8'd15 : 8'd0);

    // Colour read this cycle, buffer write with its result the next
    assign pal_rd_addr = {req.attr[3:0], pxl_word[3:0]};
    assign buf_data    = pal_rd_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_busy <= 1'b0;
            rom_cs    <= 1'b0;
            shifting  <= 1'b0;
            buf_we    <= 1'b0;
            cnt       <= '0;
        end else begin
            buf_we <= shifting;
            if (take) begin
                draw_busy <= 1'b1;
                rom_cs    <= 1'b1;
            end else if (word_in) begin
                rom_cs   <= 1'b0;
                shifting <= 1'b1;
                cnt      <= '0;
            end else if (shifting) begin
                cnt <= cnt + 1'b1;
                if (cnt == 3'd7) begin
                    shifting <= 1'b0;
                    // First half done, fetch the second word
                    if (!rom_addr[0])
                        rom_cs <= 1'b1;
                end
            end else if (draw_busy && buf_we && !rom_cs) begin
                draw_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req      <= draw_req;
            rom_addr <= {draw_req.code, draw_req.row ^ {4{req_vflip}}, 1'b0};
            pos      <= start_pos;
        end else if (word_in) begin
            pxl_word <= rom_data;
        end else if (shifting) begin
            pxl_word <= pxl_word >> 4;
            buf_addr <= pos;
            pos      <= hflip ? pos - 1'b1 : pos + 1'b1;
            if (cnt == 3'd7)
                rom_addr[0] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== obj_line_buffer.sv ====
// Double line buffer with transparent writes and erase-on-read display
`timescale 1ns/1ps
`default_nettype none
`include "obj_consts.svh"

module obj_line_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hinit,
    input  logic                  buf_we,
    input  logic [`LINE_W-1:0]    buf_addr,
    input  logic [3:0]            buf_data,
    input  logic                  pxl_cen,
    input  logic                  lhbl,
    input  logic [`LINE_W-1:0]    hdump,
    output logic [3:0]            pxl
);

    logic [3:0]    mem [2][2**`LINE_W];
    logic          disp;
    logic [3:0]    pxl_q;
    logic          rd;

    assign rd  = pxl_cen && lhbl;
    assign pxl = lhbl ? pxl_q : 4'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            disp  <= 1'b0;
            pxl_q <= 4'd0;
        end else begin
            if (hinit)
                disp <= ~disp;
            if (!lhbl)
                pxl_q <= 4'd0;
            else if (pxl_cen)
                pxl_q <= mem[disp][hdump];
        end
    end

    // Display bank is erased as it is read, the other bank takes draws
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (b == int'(disp)) begin
                if (rd)
                    mem[b][hdump] <= 4'd0;
            end else if (buf_we && buf_data != 4'd0) begin
                mem[b][buf_addr] <= buf_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== obj_engine_top.sv ====
// Sprite engine top level with register block, scan, draw and line buffer
`timescale 1ns/1ps
`default_nettype none
`include "obj_consts.svh"

module obj_engine_top (
    input  logic                  clk,
    input  logic                  rst,
    // AXI4-Lite slave
    input  logic [`AXI_AW-1:0]    awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [`AXI_AW-1:0]    araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // Graphics ROM
    output logic [`ROM_AW-1:0]    rom_addr,
    output logic                  rom_cs,
    input  logic [31:0]           rom_data,
    input  logic                  rom_ok,
    // Video timing
    input  logic                  hinit,
    input  logic                  lhbl,
    input  logic                  pxl_cen,
    input  logic [7:0]            vrender,
    input  logic [`LINE_W-1:0]    hdump,
    output logic [3:0]            pxl
);

    logic                    enable;
    logic [7:0]              hoffset;
    logic [`OBJ_IDX_W-1:0]   obj_rd_addr;
    obj_pkg::obj_entry_t     obj_rd_data;
    logic [`PAL_AW-1:0]      pal_rd_addr;
    logic [3:0]              pal_rd_data;
    obj_pkg::draw_req_t      draw_req;
    logic                    draw_valid;
    logic                    draw_busy;
    logic                    buf_we;
    logic [`LINE_W-1:0]      buf_addr;
    logic [3:0]              buf_data;

    // Port names match the wires above
    obj_axil_regs u_regs (.*);

    obj_scan u_scan (.*);

    obj_draw u_draw (.*);

    obj_line_buffer u_line_buffer (.*);

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release shortly after a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== obj_engine_assertions.sv ====
// Concurrent checks on AXI4-Lite and ROM handshakes and blanked pixel output
`timescale 1ns/1ps
`default_nettype none
`include "obj_consts.svh"

module obj_engine_assertions (
    input wire                  clk,
    input wire                  rst,
    input wire [`AXI_AW-1:0]    awaddr,
    input wire                  awvalid,
    input wire                  awready,
    input wire [31:0]           wdata,
    input wire                  wvalid,
    input wire                  wready,
    input wire                  bvalid,
    input wire                  bready,
    input wire [`AXI_AW-1:0]    araddr,
    input wire                  arvalid,
    input wire                  arready,
    input wire                  rvalid,
    input wire                  rready,
    input wire [`ROM_AW-1:0]    rom_addr,
    input wire                  rom_cs,
    input wire                  rom_ok,
    input wire                  lhbl,
    input wire [3:0]            pxl
);

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("write address dropped before ready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("write data dropped before ready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("read address dropped before ready");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("write response dropped before ready");

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("read response dropped before ready");

    // ROM request must stay put until the word arrives
    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("ROM request changed before rom_ok");

    // Blanking also clears the output register for the first active cycle
    blank_zero: assert property (@(posedge clk) disable iff (rst)
        (!lhbl || !$past(lhbl)) |-> pxl == 4'd0)
        else $error("pixel output not zero during or right after blanking");

endmodule

bind obj_engine_top obj_engine_assertions u_assert (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready),
    .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_ok(rom_ok),
    .lhbl(lhbl), .pxl(pxl)
);

`default_nettype wire

// ==== tb_obj_engine.sv ====
// Sprite engine testbench with AXI driver, ROM model, line model and checks
`timescale 1ns/1ps
`default_nettype none
`include "obj_consts.svh"

module tb_obj_engine;

    localparam int LINE_CYCLES = 1700;
    localparam int MAX_CYCLES  = 40 * LINE_CYCLES;

    logic clk, rst;
    logic [`AXI_AW-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata, rom_data;
    logic [3:0] wstrb, pxl;
    logic [1:0] bresp, rresp;
    logic [`ROM_AW-1:0] rom_addr;
    logic rom_cs, rom_ok, hinit, lhbl, pxl_cen;
    logic [7:0] vrender, hdump;

    logic [31:0] rng_state, rom_rng;
    logic [31:0] obj_m [`OBJ_COUNT];
    logic [3:0] pal_m [256];
    logic [3:0] pending [256];
    logic [3:0] shown [256];
    logic en_m;
    logic [7:0] hoff_m;
    int axi_errs, pxl_errs, checks, cycles, rom_cnt;
    bit rom_busy;

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    obj_engine_top DUT (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Graphics word for each ROM address
    function automatic logic [31:0] rom_word(input logic [`ROM_AW-1:0] a);
        return xorshift32(xorshift32({19'd0, a} + 32'h852b));
    endfunction

    // ROM answers after 1 to 4 cycles
    always @(posedge clk) begin
        #1;
        if (rom_ok) begin
            rom_ok   = 1'b0;
            rom_busy = 1'b0;
        end else if (rom_cs) begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_rng  = xorshift32(rom_rng);
                rom_cnt  = 1 + int'(rom_rng % 4);
            end
            rom_cnt--;
            if (rom_cnt == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic axi_write(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s,
                             input logic [1:0] exp_resp);
        bit acc;
        awaddr  = a;
        wdata   = d;
        wstrb   = s;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do begin
            @(negedge clk);
            acc = awready;
            if (wready != awready) begin
                $display("error %0t: write 0x%h awready %0b but wready %0b", $time, a,
                         awready, wready);
                axi_errs++;
            end
            @(posedge clk);
            #1;
        end while (!acc);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Response waits a cycle unaccepted and has to hold
        @(negedge clk);
        if (!bvalid) begin
            $display("error %0t: write 0x%h has no response a cycle after acceptance",
                     $time, a);
            axi_errs++;
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        do begin
            @(negedge clk);
            acc = bvalid;
            if (acc && bresp != exp_resp) begin
                $display("error %0t: write 0x%h resp %0d expected %0d", $time, a, bresp,
                         exp_resp);
                axi_errs++;
            end
            @(posedge clk);
            #1;
        end while (!acc);
        bready = 1'b0;
    endtask

    task automatic axi_read_check(input logic [11:0] a, input logic [31:0] exp_d,
                                  input logic [1:0] exp_resp);
        bit acc;
        araddr  = a;
        arvalid = 1'b1;
        do begin
            @(negedge clk);
            acc = arready;
            @(posedge clk);
            #1;
        end while (!acc);
        arvalid = 1'b0;
        // Read data waits a cycle unaccepted and has to hold
        @(negedge clk);
        if (!rvalid) begin
            $display("error %0t: read 0x%h has no data a cycle after acceptance", $time, a);
            axi_errs++;
        end
        @(posedge clk);
        #1;
        rready = 1'b1;
        do begin
            @(negedge clk);
            acc = rvalid;
            if (acc && (rdata != exp_d || rresp != exp_resp)) begin
                $display("error %0t: read 0x%h got %h/%0d expected %h/%0d", $time, a,
                         rdata, rresp, exp_d, exp_resp);
                axi_errs++;
            end
            @(posedge clk);
            #1;
        end while (!acc);
        rready = 1'b0;
        checks++;
    endtask

    task automatic write_obj(input int i, input logic [31:0] d);
        axi_write(`REG_OBJ_BASE + 4 * i, d, 4'hf, axil_pkg::RESP_OKAY);
        obj_m[i] = d;
    endtask

    task automatic write_ctrl(input logic en, input logic [7:0] hoff);
        axi_write(`REG_CTRL, {16'd0, hoff, 7'd0, en}, 4'b0011, axil_pkg::RESP_OKAY);
        en_m   = en;
        hoff_m = hoff;
    endtask

    // Expected line drawn for render line v
    task automatic build_line(input logic [7:0] v);
        obj_pkg::obj_entry_t e;
        logic [3:0] row, nib, col;
        logic [7:0] pos;
        logic [31:0] w;
        for (int h = 0; h < 256; h++)
            pending[h] = 4'd0;
        if (en_m) begin
            for (int i = 0; i < `OBJ_COUNT; i++) begin
                e = obj_m[i];
                if (e.y <= v && {1'b0, v} < {1'b0, e.y} + 9'd16) begin
                    row = 4'(v - e.y);
                    if (e.attr[7])
                        row = ~row;
                    pos = e.x + hoff_m + (e.attr[6] ? 8'd15 : 8'd0);
                    for (int half = 0; half < 2; half++) begin
                        w = rom_word({e.code, row, half[0]});
                        for (int p = 0; p < 8; p++) begin
                            nib = w[4*p +: 4];
                            col = pal_m[{e.attr[3:0], nib}];
                            if (col != 4'd0)
                                pending[pos] = col;
                            pos = e.attr[6] ? pos - 8'd1 : pos + 8'd1;
                        end
                    end
                end
            end
        end
    endtask

    // One video line with bank swap, display sweep of the previous drawing and idle tail
    task automatic run_line(input logic [7:0] v, input bit check);
        for (int h = 0; h < 256; h++)
            shown[h] = pending[h];
        build_line(v);
        vrender = v;
        hinit   = 1'b1;
        @(posedge clk);
        #1;
        hinit = 1'b0;
        lhbl  = 1'b1;
        for (int h = 0; h < 256; h++) begin
            hdump   = 8'(h);
            pxl_cen = 1'b1;
            @(posedge clk);
            #1;
            pxl_cen = 1'b0;
            if (check && pxl != shown[h]) begin
                $display("error %0t: pixel %0d got %0d expected %0d", $time, h, pxl,
                         shown[h]);
                pxl_errs++;
            end
            checks++;
            @(posedge clk);
            #1;
        end
        lhbl = 1'b0;
        repeat (LINE_CYCLES - 513) @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0] v0;
        obj_pkg::obj_entry_t e;
        rng_state = 32'h852b;
        rom_rng   = xorshift32(32'h852b);
        awaddr    = '0;
        awvalid   = 0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 0;
        bready    = 0;
        araddr    = '0;
        arvalid   = 0;
        rready    = 0;
        rom_data  = '0;
        rom_ok    = 0;
        rom_busy  = 0;
        rom_cnt   = 0;
        hinit     = 0;
        lhbl      = 0;
        pxl_cen   = 0;
        vrender   = '0;
        hdump     = '0;
        axi_errs  = 0;
        pxl_errs  = 0;
        checks    = 0;
        cycles    = 0;
        en_m = 1'b0;
        hoff_m = `HOFFSET_RST;
        for (int h = 0; h < 256; h++)
            pending[h] = 4'd0;
        @(negedge rst);
        @(posedge clk);
        #1;

        // Register access, strobes and decode errors
        axi_read_check(`REG_CTRL, {16'd0, `HOFFSET_RST, 8'd0}, axil_pkg::RESP_OKAY);
        write_obj(3, 32'h11223344);
        axi_write(`REG_OBJ_BASE + 12, 32'hAABBCCDD, 4'b0101, axil_pkg::RESP_OKAY);
        obj_m[3] = 32'h11BB33DD;
        axi_read_check(`REG_OBJ_BASE + 12, obj_m[3], axil_pkg::RESP_OKAY);
        axi_write(12'h460, 32'hFFFFFFFF, 4'hf, axil_pkg::RESP_SLVERR);
        axi_read_check(12'h460, 32'd0, axil_pkg::RESP_SLVERR);
        axi_read_check(12'h004, 32'd0, axil_pkg::RESP_SLVERR);
        for (int i = 0; i < 256; i++) begin
            r = next_rand();
            pal_m[i] = r[3:0];
            axi_write(`REG_PAL_BASE + 4 * i, {28'd0, r[3:0]}, 4'h1, axil_pkg::RESP_OKAY);
        end
        axi_read_check(`REG_PAL_BASE + 4 * 77, {28'd0, pal_m[77]}, axil_pkg::RESP_OKAY);

        // Both banks start undefined and are read once to clear them
        run_line(8'd0, 1'b0);
        run_line(8'd0, 1'b0);

        // Random tables with overlapping objects near a chosen line
        for (int s = 0; s < 6; s++) begin
            v0 = 8'(next_rand());
            for (int i = 0; i < `OBJ_COUNT; i++) begin
                r = next_rand();
                e.y    = v0 - 8'(r[4:0] % 20);
                e.attr = r[15:8];
                e.code = r[23:16];
                e.x    = (s[0] ? 8'd232 : v0) + 8'(r[28:24]);
                write_obj(i, e);
            end
            r = next_rand();
            write_ctrl(1'b1, r[7:0]);
            axi_read_check(`REG_CTRL, {16'd0, r[7:0], 8'd1}, axil_pkg::RESP_OKAY);
            for (int l = 0; l < 4; l++)
                run_line(v0 + 8'(next_rand() % 6), 1'b1);
        end

        // Drawn line, empty line, then a line with enable off
        for (int i = 0; i < `OBJ_COUNT; i++) begin
            e = obj_m[i];
            e.y = 8'd100;
            write_obj(i, e);
        end
        run_line(8'd105, 1'b1);
        run_line(8'd20, 1'b1);
        run_line(8'd110, 1'b1);
        write_ctrl(1'b0, hoff_m);
        run_line(8'd105, 1'b1);
        run_line(8'd0, 1'b1);

        $display("checks %0d, axi errors %0d, pixel errors %0d", checks, axi_errs, pxl_errs);
        if (axi_errs == 0 && pxl_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
obj_pkg.sv
axil_pkg.sv
obj_axil_regs.sv
obj_scan.sv
obj_draw.sv
obj_line_buffer.sv
obj_engine_top.sv
tb_clk_gen.sv
obj_engine_assertions.sv
tb_obj_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_obj_engine -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
